// File: icache_pkg.sv
package icache_pkg;

  // direct-mapped icache, 8 KB
  // 128 lines of 64 bytes, fetch word and memory beat both 32 bits
  // address split: tag 31..13, index 12..6, word 5..2, byte 1..0

  // full byte address on the fetch and memory sides
  typedef logic [31:0] addr_t;

  // one instruction, also one memory beat
  typedef logic [31:0] word_t;

  // line tag from address bits 31..13
  typedef logic [18:0] tag_t;

  // line number from address bits 12..6
  typedef logic [6:0] index_t;

  // word within a line from address bits 5..2
  typedef logic [3:0] beat_t;

  // lines in the cache
  localparam int LINE_COUNT = 128;

  // 32-bit words per 64-byte line
  localparam int BEATS_PER_LINE = 16;

  // burst length minus one, as driven on mem_rlen_o
  localparam logic [7:0] BURST_LEN_LINE = 8'd15;
  localparam logic [7:0] BURST_LEN_SINGLE = 8'd0;

  // everything below this address bypasses the arrays
  localparam addr_t UNCACHE_LIMIT = 32'h8000_0000;

  // controller states
  // RST: one cycle after reset before taking requests
  // IDLE: samples a new fetch request
  // LOOKUP: tag compare, ack on hit, may sample the next request
  // REFILL: 16-beat line burst from memory
  // UNCACHE: single-beat read, bypasses the arrays
  // UNCACHE_DONE: returns the captured word with the ack
  typedef enum logic [2:0] {
    CTRL_RST,
    CTRL_IDLE,
    CTRL_LOOKUP,
    CTRL_REFILL,
    CTRL_UNCACHE,
    CTRL_UNCACHE_DONE
  } ctrl_state_t;

endpackage

// File: icache_beat_counter.sv
`timescale 1ns/10ps

module icache_beat_counter (
  input  logic               clk,
  input  logic               rst,
  // back to word 0 before a new burst
  input  logic               clear_i,
  // one accepted memory beat
  input  logic               beat_i,
  output icache_pkg::beat_t  count_o,
  output logic               last_o
);

  // word number of the next beat to be written
  icache_pkg::beat_t count_q;

  // clear wins over a beat in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (beat_i) begin
      // wraps to zero after the last word of the line
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

  // high during the final beat of a line burst
  assign last_o = (count_q == icache_pkg::beat_t'(icache_pkg::BEATS_PER_LINE - 1));

endmodule

// File: icache_tag_array.sv
`timescale 1ns/10ps

module icache_tag_array (
  input  logic                clk,
  input  logic                rst,
  // registered request fields from the controller
  input  icache_pkg::index_t  index_i,
  input  icache_pkg::tag_t    tag_i,
  // strobe at the end of a refill
  input  logic                write_i,
  output logic                hit_o
);

  // one valid bit per line
  logic [icache_pkg::LINE_COUNT-1:0] valid_q;

  // stored tags, only meaningful where valid is set
  icache_pkg::tag_t tag_mem [icache_pkg::LINE_COUNT];

  // valid bits start cleared, so nothing hits after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (write_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  // tag storage
  always_ff @(posedge clk) begin
    if (write_i) begin
      tag_mem[index_i] <= tag_i;
    end
  end

  // combinational compare
  // the refilled line is visible in the cycle after the write
  assign hit_o = valid_q[index_i] && (tag_mem[index_i] == tag_i);

endmodule

// File: icache_data_array.sv
`timescale 1ns/10ps

module icache_data_array (
  input  logic                clk,
  // read side follows the fetch address directly
  input  icache_pkg::index_t  rd_index_i,
  input  icache_pkg::beat_t   rd_beat_i,
  // write side, one word per refill beat
  input  icache_pkg::index_t  wr_index_i,
  input  icache_pkg::beat_t   wr_beat_i,
  input  logic                wr_en_i,
  input  icache_pkg::word_t   wr_data_i,
  output icache_pkg::word_t   rd_data_o
);

  localparam int WORD_COUNT = icache_pkg::LINE_COUNT * icache_pkg::BEATS_PER_LINE;
  localparam int ADDR_W = $bits(icache_pkg::index_t) + $bits(icache_pkg::beat_t);

  // 2048 words, line number in the upper address bits
  icache_pkg::word_t mem [WORD_COUNT];

  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W-1:0] wr_addr;

  assign rd_addr = {rd_index_i, rd_beat_i};
  assign wr_addr = {wr_index_i, wr_beat_i};

  // refill beats land here
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr] <= wr_data_i;
    end
  end

  // registered read
  // the word sampled with the request is out in the lookup cycle
  always_ff @(posedge clk) begin
    rd_data_o <= mem[rd_addr];
  end

endmodule

// File: icache_ctrl.sv
`timescale 1ns/10ps

module icache_ctrl (
  input  logic                clk,
  input  logic                rst,
  // fetch side
  input  logic                fetch_req_i,
  input  icache_pkg::addr_t   fetch_addr_i,
  output logic                fetch_ack_o,
  // from tag array and beat counter
  input  logic                hit_i,
  input  logic                beat_last_i,
  // memory return path
  input  logic                mem_rready_i,
  input  icache_pkg::word_t   mem_rdata_i,
  // to the arrays and counter
  output icache_pkg::index_t  req_index_o,
  output icache_pkg::tag_t    req_tag_o,
  output logic                beat_clear_o,
  output logic                beat_en_o,
  output logic                tag_write_o,
  output logic                data_wen_o,
  output icache_pkg::word_t   uncache_data_o,
  output logic                uncache_sel_o,
  // memory request
  output icache_pkg::addr_t   mem_raddr_o,
  output logic [7:0]          mem_rlen_o,
  output logic                mem_rvalid_o
);

  icache_pkg::ctrl_state_t state_q;

  // sampled request fields
  icache_pkg::tag_t   req_tag_q;
  icache_pkg::index_t req_index_q;
  icache_pkg::beat_t  req_beat_q;

  // memory request registers
  icache_pkg::addr_t  mem_raddr_q;
  logic [7:0]         mem_rlen_q;
  logic               mem_rvalid_q;

  // word returned by an uncached read
  icache_pkg::word_t  uncache_data_q;

  icache_pkg::addr_t  req_addr;
  logic               req_uncached;
  logic               in_lookup;
  logic               lookup_hit;
  logic               lookup_miss;
  logic               lookup_uncache;
  logic               sample_req;
  logic               mem_beat;
  logic               refill_beat;

  assign req_addr = {req_tag_q, req_index_q, req_beat_q, 2'b00};

  // uncached region is everything below the limit
  assign req_uncached = (req_addr < icache_pkg::UNCACHE_LIMIT);

  assign in_lookup = (state_q == icache_pkg::CTRL_LOOKUP);
  assign lookup_hit = in_lookup && !req_uncached && hit_i;
  assign lookup_miss = in_lookup && !req_uncached && !hit_i;
  assign lookup_uncache = in_lookup && req_uncached;

  // new request taken in idle, or right behind a hit
  assign sample_req = (state_q == icache_pkg::CTRL_IDLE) || lookup_hit;

  // beat accepted by the memory side
  assign mem_beat = mem_rvalid_q && mem_rready_i;
  assign refill_beat = (state_q == icache_pkg::CTRL_REFILL) && mem_beat;

  // request fields, held while a miss is being serviced
  always_ff @(posedge clk) begin
    if (sample_req) begin
      req_tag_q <= fetch_addr_i[31:13];
      req_index_q <= fetch_addr_i[12:6];
      req_beat_q <= fetch_addr_i[5:2];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= icache_pkg::CTRL_RST;
      mem_rvalid_q <= 1'b0;
    end else begin
      case (state_q)
        icache_pkg::CTRL_RST: begin
          state_q <= icache_pkg::CTRL_IDLE;
        end
        icache_pkg::CTRL_IDLE: begin
          if (fetch_req_i) begin
            state_q <= icache_pkg::CTRL_LOOKUP;
          end
        end
        icache_pkg::CTRL_LOOKUP: begin
          if (req_uncached) begin
            state_q <= icache_pkg::CTRL_UNCACHE;
            mem_rvalid_q <= 1'b1;
          end else if (hit_i) begin
            // stay here if the core has the next request ready
            state_q <= fetch_req_i ? icache_pkg::CTRL_LOOKUP : icache_pkg::CTRL_IDLE;
          end else begin
            state_q <= icache_pkg::CTRL_REFILL;
            mem_rvalid_q <= 1'b1;
          end
        end
        icache_pkg::CTRL_REFILL: begin
          // back through idle, the held request then hits
          if (mem_beat && beat_last_i) begin
            state_q <= icache_pkg::CTRL_IDLE;
            mem_rvalid_q <= 1'b0;
          end
        end
        icache_pkg::CTRL_UNCACHE: begin
          if (mem_beat) begin
            state_q <= icache_pkg::CTRL_UNCACHE_DONE;
            mem_rvalid_q <= 1'b0;
          end
        end
        icache_pkg::CTRL_UNCACHE_DONE: begin
          state_q <= icache_pkg::CTRL_IDLE;
        end
        default: begin
          state_q <= icache_pkg::CTRL_IDLE;
        end
      endcase
    end
  end

  // address and length, stable until the last beat
  always_ff @(posedge clk) begin
    if (lookup_miss) begin
      // line base, 16 beats
      mem_raddr_q <= {req_tag_q, req_index_q, 6'b0};
      mem_rlen_q <= icache_pkg::BURST_LEN_LINE;
    end else if (lookup_uncache) begin
      // exact word, one beat
      mem_raddr_q <= req_addr;
      mem_rlen_q <= icache_pkg::BURST_LEN_SINGLE;
    end
  end

  // capture the single uncached beat
  always_ff @(posedge clk) begin
    if ((state_q == icache_pkg::CTRL_UNCACHE) && mem_beat) begin
      uncache_data_q <= mem_rdata_i;
    end
  end

  assign fetch_ack_o = lookup_hit || (state_q == icache_pkg::CTRL_UNCACHE_DONE);
  assign uncache_sel_o = (state_q == icache_pkg::CTRL_UNCACHE_DONE);
  assign uncache_data_o = uncache_data_q;

  assign req_index_o = req_index_q;
  assign req_tag_o = req_tag_q;

  // counter starts at word 0 for each refill
  assign beat_clear_o = lookup_miss;
  assign beat_en_o = refill_beat;
  assign data_wen_o = refill_beat;
  // tag goes valid together with the last data word
  assign tag_write_o = refill_beat && beat_last_i;

  assign mem_raddr_o = mem_raddr_q;
  assign mem_rlen_o = mem_rlen_q;
  assign mem_rvalid_o = mem_rvalid_q;

endmodule

// File: icache_top.sv
`timescale 1ns/10ps

module icache_top (
  input  logic               clk,
  input  logic               rst,
  // fetch side, request held until ack
  input  logic               fetch_req_i,
  input  icache_pkg::addr_t  fetch_addr_i,
  output logic               fetch_ack_o,
  output icache_pkg::word_t  fetch_data_o,
  // memory read side
  output icache_pkg::addr_t  mem_raddr_o,
  output logic [7:0]         mem_rlen_o,
  output logic               mem_rvalid_o,
  input  logic               mem_rready_i,
  input  icache_pkg::word_t  mem_rdata_i
);

  logic               hit;
  logic               beat_last;
  icache_pkg::beat_t  beat_count;
  icache_pkg::index_t req_index;
  icache_pkg::tag_t   req_tag;
  logic               beat_clear;
  logic               beat_en;
  logic               tag_write;
  logic               data_wen;
  icache_pkg::word_t  uncache_data;
  logic               uncache_sel;
  icache_pkg::word_t  rd_data;

  icache_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .fetch_req_i    (fetch_req_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ack_o    (fetch_ack_o),
    .hit_i          (hit),
    .beat_last_i    (beat_last),
    .mem_rready_i   (mem_rready_i),
    .mem_rdata_i    (mem_rdata_i),
    .req_index_o    (req_index),
    .req_tag_o      (req_tag),
    .beat_clear_o   (beat_clear),
    .beat_en_o      (beat_en),
    .tag_write_o    (tag_write),
    .data_wen_o     (data_wen),
    .uncache_data_o (uncache_data),
    .uncache_sel_o  (uncache_sel),
    .mem_raddr_o    (mem_raddr_o),
    .mem_rlen_o     (mem_rlen_o),
    .mem_rvalid_o   (mem_rvalid_o)
  );

  icache_beat_counter u_beat_counter (
    .clk     (clk),
    .rst     (rst),
    .clear_i (beat_clear),
    .beat_i  (beat_en),
    .count_o (beat_count),
    .last_o  (beat_last)
  );

  icache_tag_array u_tag_array (
    .clk     (clk),
    .rst     (rst),
    .index_i (req_index),
    .tag_i   (req_tag),
    .write_i (tag_write),
    .hit_o   (hit)
  );

  // read straight from the fetch address so data lines up with the lookup cycle
  icache_data_array u_data_array (
    .clk        (clk),
    .rd_index_i (fetch_addr_i[12:6]),
    .rd_beat_i  (fetch_addr_i[5:2]),
    .wr_index_i (req_index),
    .wr_beat_i  (beat_count),
    .wr_en_i    (data_wen),
    .wr_data_i  (mem_rdata_i),
    .rd_data_o  (rd_data)
  );

  // uncached word only in the uncached ack cycle
  assign fetch_data_o = uncache_sel ? uncache_data : rd_data;

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  // 40 ns period, first rising edge at 20 ns
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // high over 5 rising edges, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// File: icache_tb.sv
`timescale 1ns/10ps

module icache_tb;

  logic               clk;
  logic               rst;
  logic               fetch_req_i;
  icache_pkg::addr_t  fetch_addr_i;
  logic               fetch_ack_o;
  icache_pkg::word_t  fetch_data_o;
  icache_pkg::addr_t  mem_raddr_o;
  logic [7:0]         mem_rlen_o;
  logic               mem_rvalid_o;
  logic               mem_rready_i;
  icache_pkg::word_t  mem_rdata_i;

  // error counts, one owner process each
  int data_errors;
  int mem_errors;
  int fetch_errors;

  // every fetch address in issue order, acks consume them in order
  icache_pkg::addr_t expect_q[$];
  int ack_count;

  // memory model state
  icache_pkg::addr_t burst_addrs[$];
  logic [7:0]        burst_lens[$];
  icache_pkg::addr_t cur_addr;
  logic [7:0]        cur_len;
  int                beat_idx;
  logic              in_burst;
  logic              last_valid;
  logic              burst_done;
  logic              heavy_stall;
  icache_pkg::word_t exp_word;

  tb_clock_gen u_clock_gen (.clk(clk), .rst(rst));

  icache_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .fetch_req_i  (fetch_req_i),
    .fetch_addr_i (fetch_addr_i),
    .fetch_ack_o  (fetch_ack_o),
    .fetch_data_o (fetch_data_o),
    .mem_raddr_o  (mem_raddr_o),
    .mem_rlen_o   (mem_rlen_o),
    .mem_rvalid_o (mem_rvalid_o),
    .mem_rready_i (mem_rready_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  // memory contents as a fixed mix of the byte address
  function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t addr);
    icache_pkg::word_t w;
    w = addr * 32'h9e37_79b1;
    w = w ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_0f96;
    return w;
  endfunction

  task automatic finish_run();
    $display("errors: %0d data, %0d memory, %0d fetch", data_errors, mem_errors,
             fetch_errors);
    if (data_errors + mem_errors + fetch_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  // one fetch, returns the falling edges from drive to ack
  task automatic fetch(input icache_pkg::addr_t addr, output int cycles);
    fetch_req_i = 1'b1;
    fetch_addr_i = addr;
    expect_q.push_back(addr);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (fetch_ack_o !== 1'b1 && cycles < 1000);
    if (fetch_ack_o !== 1'b1) begin
      fetch_errors++;
      $display("no acknowledge for the fetch of %08h within 1000 cycles", addr);
      finish_run();
    end else begin
      // released here, the next call may raise it again at once
      fetch_req_i = 1'b0;
    end
  endtask

  // settle to a rising edge so the memory model is quiet
  task automatic check_bursts(input int count, input icache_pkg::addr_t addr,
                              input logic [7:0] len);
    @(posedge clk);
    if (burst_addrs.size() != count) begin
      fetch_errors++;
      $display("wrong number of memory bursts at %0t: %0d seen, %0d expected", $time,
               burst_addrs.size(), count);
    end else begin
      if (burst_addrs[count-1] !== addr) begin
        fetch_errors++;
        $display("Error at %0t: mem_raddr_o got %08h expected %08h", $time,
                 burst_addrs[count-1], addr);
      end
      if (burst_lens[count-1] !== len) begin
        fetch_errors++;
        $display("Error at %0t: mem_rlen_o got %0d expected %0d", $time,
                 burst_lens[count-1], len);
      end
    end
    @(negedge clk);
  endtask

  // memory side, random ready, one word per accepted beat
  initial begin
    mem_errors = 0;
    mem_rready_i = 1'b0;
    mem_rdata_i = '0;
    in_burst = 1'b0;
    last_valid = 1'b0;
    beat_idx = 0;
    forever begin
      @(negedge clk);
      burst_done = 1'b0;
      // beat taken at the last rising edge
      if (last_valid && mem_rready_i && in_burst) begin
        beat_idx++;
        if (beat_idx > int'(cur_len)) begin
          in_burst = 1'b0;
          burst_done = 1'b1;
        end
      end
      if (burst_done && mem_rvalid_o === 1'b1) begin
        mem_errors++;
        $display("mem_rvalid_o still high in the cycle after the last beat at %0t", $time);
      end else if (!in_burst && mem_rvalid_o === 1'b1) begin
        // new request
        burst_addrs.push_back(mem_raddr_o);
        burst_lens.push_back(mem_rlen_o);
        cur_addr = mem_raddr_o;
        cur_len = mem_rlen_o;
        beat_idx = 0;
        in_burst = 1'b1;
      end else if (in_burst) begin
        if (mem_rvalid_o !== 1'b1) begin
          mem_errors++;
          $display("Error at %0t: mem_rvalid_o got %b expected 1", $time, mem_rvalid_o);
        end
        if (mem_raddr_o !== cur_addr) begin
          mem_errors++;
          $display("Error at %0t: mem_raddr_o got %08h expected %08h", $time,
                   mem_raddr_o, cur_addr);
        end
        if (mem_rlen_o !== cur_len) begin
          mem_errors++;
          $display("Error at %0t: mem_rlen_o got %0d expected %0d", $time,
                   mem_rlen_o, cur_len);
        end
      end
      last_valid = (mem_rvalid_o === 1'b1);
      if (heavy_stall) begin
        mem_rready_i = ($urandom_range(1, 0) == 1);
      end else begin
        mem_rready_i = ($urandom_range(3, 0) != 0);
      end
      if (in_burst) begin
        mem_rdata_i = mem_word(cur_addr + 32'(beat_idx * 4));
      end else begin
        mem_rdata_i = '0;
      end
    end
  end

  // compare on every ack against the oldest unanswered fetch
  initial begin
    data_errors = 0;
    ack_count = 0;
    forever begin
      @(negedge clk);
      if (fetch_ack_o === 1'b1) begin
        if (ack_count >= expect_q.size()) begin
          data_errors++;
          $display("acknowledge at %0t with no fetch outstanding", $time);
        end else begin
          exp_word = mem_word(expect_q[ack_count]);
          if (fetch_data_o !== exp_word) begin
            data_errors++;
            $display("Error at %0t: fetch_data_o got %08h expected %08h (addr %08h)",
                     $time, fetch_data_o, exp_word, expect_q[ack_count]);
          end
        end
        ack_count++;
      end
    end
  end

  initial begin
    int cycles;
    int base_bursts;
    logic was_rst;
    icache_pkg::addr_t line_a;
    icache_pkg::addr_t line_b;
    icache_pkg::addr_t unc_addr;
    icache_pkg::addr_t rnd_addr;
    void'($urandom(32'h37b4));
    fetch_errors = 0;
    heavy_stall = 1'b0;
    fetch_req_i = 1'b0;
    fetch_addr_i = '0;

    // quiet outputs through reset and the cycle after it
    cycles = 0;
    was_rst = 1'b1;
    while (was_rst && cycles < 20) begin
      @(posedge clk);
      was_rst = rst;
      @(negedge clk);
      cycles++;
      if (fetch_ack_o !== 1'b0) begin
        fetch_errors++;
        $display("Error at %0t: fetch_ack_o got %b expected 0", $time, fetch_ack_o);
      end
      if (mem_rvalid_o !== 1'b0) begin
        fetch_errors++;
        $display("Error at %0t: mem_rvalid_o got %b expected 0", $time, mem_rvalid_o);
      end
    end
    if (was_rst) begin
      fetch_errors++;
      $display("reset still asserted after 20 cycles");
      finish_run();
    end

    line_a = 32'h8000_1040;
    // same index, next tag
    line_b = line_a + 32'h2000;
    unc_addr = 32'h0000_3a44;

    // miss, then all 16 words hit with no further burst
    base_bursts = burst_addrs.size();
    fetch(line_a + 32'h14, cycles);
    check_bursts(base_bursts + 1, line_a, 8'd15);
    for (int i = 0; i < 16; i++) begin
      fetch(line_a + 32'(i * 4), cycles);
      if (cycles != 1) begin
        fetch_errors++;
        $display("hit on %08h acknowledged after %0d cycles instead of 1",
                 line_a + 32'(i * 4), cycles);
      end
    end
    check_bursts(base_bursts + 1, line_a, 8'd15);

    // conflict eviction and return
    fetch(line_b + 32'h8, cycles);
    check_bursts(base_bursts + 2, line_b, 8'd15);
    fetch(line_a + 32'h3c, cycles);
    check_bursts(base_bursts + 3, line_a, 8'd15);

    // uncached word, twice
    fetch(unc_addr, cycles);
    check_bursts(base_bursts + 4, unc_addr, 8'd0);
    fetch(unc_addr, cycles);
    check_bursts(base_bursts + 5, unc_addr, 8'd0);

    // random mix under heavier back-pressure
    // 4 tags over all lines keeps a share of hits
    heavy_stall = 1'b1;
    for (int i = 0; i < 60; i++) begin
      if ($urandom_range(3, 0) == 0) begin
        rnd_addr = $urandom & 32'h7fff_fffc;
      end else begin
        rnd_addr = 32'h8000_0000 | ($urandom & 32'h0000_7ffc);
      end
      fetch(rnd_addr, cycles);
    end

    @(posedge clk);
    if (ack_count != expect_q.size()) begin
      fetch_errors++;
      $display("%0d acknowledges seen for %0d fetches", ack_count, expect_q.size());
    end
    finish_run();
  end

endmodule

// File: icache_top.f
icache_pkg.sv
icache_beat_counter.sv
icache_tag_array.sv
icache_data_array.sv
icache_ctrl.sv
icache_top.sv
tb_clock_gen.sv
icache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f icache_top.f --top-module icache_tb -o icache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/icache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed" sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
